/* compile.f */
+incdir+verilog
verilog/cpc_pkg.sv
verilog/rom_boot_loader.sv
verilog/mf2_unit.sv
verilog/mem_port_arbiter.sv
verilog/cpc_mem_top.sv
test/wb_sdram_model.sv
test/tb_cpc_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory-side testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f compile.f --top-module tb_cpc_mem \
    --Mdir obj_dir -o tb_cpc_mem

status=0
./obj_dir/tb_cpc_mem > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    exit 1
fi

/* test/tb_cpc_mem.sv */
`timescale 1ns/1ps

`include "cpc_defs.svh"

module tb_cpc_mem;

    localparam int DL_BYTES       = 131072;                 // 128 KB image
    localparam int NUM_READS      = 64;
    // Worst case 10 cycles per stored byte, 2 per skipped byte, 8 per CPU access
    localparam int TIMEOUT_CYCLES = 2 * (10 + 65536 * 10 + 65536 * 2 + (NUM_READS + 40) * 8);

    logic               clk_48 = 1'b0;
    logic               RESET;
    cpc_pkg::ioctl_t    ioctl;
    cpc_pkg::cpu_bus_t  cpu;
    logic               key_nmi;
    logic               ioctl_wait, rom_loaded, cpu_ack, nmi;
    cpc_pkg::byte_t     cpu_din;
    logic               wb_cyc, wb_stb, wb_we, wb_ack;
    cpc_pkg::mem_addr_t wb_adr;
    cpc_pkg::byte_t     wb_dat_w, wb_dat_r;

    cpc_pkg::mem_req_t  exp_wr_q [$];                       // Loader writes still due
    cpc_pkg::byte_t     sdram_exp [cpc_pkg::mem_addr_t];    // Expected SDRAM content
    cpc_pkg::byte_t     mf2_exp [cpc_pkg::mf2_addr_t];      // Expected shadow bytes
    cpc_pkg::mem_addr_t last_adr = '0;                      // Last acked Wishbone address
    logic [31:0]        lfsr_q = 32'h2bc378ff;
    logic [4:0]         tb_pen = '0;
    logic [3:0]         tb_crtc = '0;
    int                 wb_count = 0, checks = 0, errors = 0, cycle_cnt = 0;

    always #4 clk_48 = ~clk_48;                             // 8 ns period

    cpc_mem_top cpc_mem_top_i (
        .clk_48(clk_48), .RESET(RESET), .ioctl(ioctl), .ioctl_wait(ioctl_wait),
        .rom_loaded(rom_loaded), .cpu(cpu), .key_nmi(key_nmi), .cpu_din(cpu_din),
        .cpu_ack(cpu_ack), .nmi(nmi), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    wb_sdram_model sdram_i (
        .clk_48(clk_48), .RESET(RESET), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_q = lfsr_next(lfsr_q);                     // One step per bit
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Where a download byte must land, valid low when it is dropped
    function automatic cpc_pkg::mem_req_t tb_expect(input logic [24:0] dl_addr,
                                                     input cpc_pkg::byte_t data);
        cpc_pkg::rom_slot_t slot_map [4];
        cpc_pkg::mem_req_t  r;
        slot_map[0] = `CPC_SLOT_OS;
        slot_map[1] = `CPC_SLOT_BASIC;
        slot_map[2] = `CPC_SLOT_AMSDOS;
        slot_map[3] = `CPC_SLOT_MF2;
        r.valid = dl_addr < `CPC_IMAGE_LIMIT;
        r.we    = 1'b1;
        r.addr  = {slot_map[dl_addr[15:14]], dl_addr[13:0]};
        r.data  = data;
        return r;
    endfunction

    // MF2 RAM location of an I/O write, zero when not kept
    function automatic cpc_pkg::mf2_addr_t shadow_addr(input logic [7:0] port,
                                                       input cpc_pkg::byte_t data);
        cpc_pkg::mf2_addr_t sa;
        sa = '0;
        if (port == 8'h7F && data[7:6] == 2'b00) sa = `MF2_ST_PEN;
        if (port == 8'h7F && data[7:6] == 2'b01)
            sa = tb_pen[4] ? `MF2_ST_BORDER : `MF2_ST_PALETTE_BASE + 13'(tb_pen[3:0]);
        if (port == 8'h7F && data[7:6] == 2'b10) sa = `MF2_ST_MODE;
        if (port == 8'h7F && data[7:6] == 2'b11) sa = `MF2_ST_BANK;
        if (port == 8'hBC) sa = `MF2_ST_CRTC_SEL;
        if (port == 8'hBD) sa = `MF2_ST_CRTC_BASE + 13'(tb_crtc);
        if (port == 8'hF7) sa = `MF2_ST_PPI;
        if (port == 8'hDF) sa = `MF2_ST_UROM;
        return sa;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // CPU bus tasks, entered and left on a falling edge
    task automatic cpu_access(input logic we, input cpc_pkg::cpu_addr_t addr,
                              input cpc_pkg::byte_t wdata, output cpc_pkg::byte_t rdata,
                              output int lat);
        lat        = 0;
        cpu.addr   = addr;
        cpu.dout   = wdata;
        cpu.mem_rd = !we;
        cpu.mem_wr = we;
        do begin
            @(negedge clk_48);
            lat++;
        end while (!cpu_ack);                               // Timeout ends a hang
        rdata      = cpu_din;
        cpu.mem_rd = 1'b0;
        cpu.mem_wr = 1'b0;
        @(negedge clk_48);                                  // Bus idle before the next request
    endtask

    task automatic read_and_compare(input cpc_pkg::cpu_addr_t addr,
                                    input cpc_pkg::mem_addr_t exp_adr, input string what);
        cpc_pkg::byte_t rd;
        int             lat;
        cpu_access(1'b0, addr, 8'h00, rd, lat);
        check_equal({what, " Wishbone address"}, 32'(last_adr), 32'(exp_adr));
        check_equal({what, " data"}, 32'(rd), 32'(sdram_exp[exp_adr]));
    endtask

    task automatic io_write(input cpc_pkg::cpu_addr_t addr, input cpc_pkg::byte_t data);
        cpc_pkg::mf2_addr_t sa;
        sa = shadow_addr(addr[15:8], data);
        if (sa != '0) mf2_exp[sa] = data;
        if (addr[15:8] == 8'h7F && data[7:6] == 2'b00) tb_pen = data[4:0];
        if (addr[15:8] == 8'hBC) tb_crtc = data[3:0];
        cpu.addr  = addr;
        cpu.dout  = data;
        cpu.io_wr = 1'b1;
        @(negedge clk_48);
        cpu.io_wr = 1'b0;
        @(negedge clk_48);
    endtask

    task automatic m1_fetch(input cpc_pkg::cpu_addr_t addr);
        cpu.addr = addr;
        cpu.m1   = 1'b1;
        @(negedge clk_48);
        cpu.m1   = 1'b0;
        @(negedge clk_48);
    endtask

    task automatic pulse_nmi_key();
        key_nmi = 1'b1;
        @(negedge clk_48);
        key_nmi = 1'b0;
        check_equal("nmi after key", 32'(nmi), 32'd1);
    endtask

    // ------------------------------------------------------------
    // Wishbone compare process, loader writes against the queue
    always @(negedge clk_48) begin
        cpc_pkg::mem_req_t e;
        if (!RESET && wb_cyc && wb_stb && wb_ack) begin
            wb_count++;
            last_adr = wb_adr;
            if (wb_we && exp_wr_q.size() == 0) begin
                errors++;
                $display("Unexpected Wishbone write of %02h to %06h at %0t ns",
                         wb_dat_w, wb_adr, $time);
            end else if (wb_we) begin
                e = exp_wr_q.pop_front();
                check_equal("loader write address", 32'(wb_adr), 32'(e.addr));
                check_equal("loader write data", 32'(wb_dat_w), 32'(e.data));
            end
        end
    end

    always @(posedge clk_48) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    initial begin
        cpc_pkg::mem_req_t  req;
        cpc_pkg::mf2_addr_t keys [$];
        logic [31:0]        bits;
        cpc_pkg::byte_t     rd;
        int                 lat, wb_before;
        RESET   = 1'b1;
        ioctl   = '0;
        cpu     = '0;
        key_nmi = 1'b0;
        repeat (10) @(negedge clk_48);
        RESET   = 1'b0;
        @(negedge clk_48);
        // Handshakes, wait, nmi and rom_loaded all idle out of reset
        check_equal("outputs after reset",
                    32'({ioctl_wait, rom_loaded, cpu_ack, nmi, wb_cyc, wb_stb}), 32'd0);

        // Download of 128 KB, upper half is dropped
        ioctl.download = 1'b1;
        for (int i = 0; i < DL_BYTES; i++) begin
            take_bits(8, bits);
            req = tb_expect(25'(i), bits[7:0]);
            if (req.valid) begin
                exp_wr_q.push_back(req);
                sdram_exp[req.addr] = req.data;
            end
            ioctl.addr = 25'(i);
            ioctl.dout = bits[7:0];
            ioctl.wr   = 1'b1;
            @(negedge clk_48);
            ioctl.wr   = 1'b0;
            @(negedge clk_48);
            while (ioctl_wait) @(negedge clk_48);          // Host back-pressure
        end
        check_equal("loader writes left", 32'(exp_wr_q.size()), 32'd0);
        check_equal("rom_loaded during download", 32'(rom_loaded), 32'd0);
        ioctl.download = 1'b0;
        @(negedge clk_48);
        check_equal("rom_loaded after download", 32'(rom_loaded), 32'd1);

        // Plain reads of the OS ROM
        for (int n = 0; n < NUM_READS; n++) begin
            take_bits(14, bits);
            read_and_compare({2'b00, bits[13:0]}, {7'd0, 2'b00, bits[13:0]}, "OS read");
        end

        // NMI entry maps the MF2 ROM over 0000-1FFF
        pulse_nmi_key();
        m1_fetch(`MF2_NMI_ENTRY);
        check_equal("nmi after entry", 32'(nmi), 32'd0);
        read_and_compare(16'h0123, {`CPC_SLOT_MF2, 14'h0123}, "MF2 ROM read");

        // Register shadowing into MF2 RAM
        io_write(16'h7F00, 8'h03);                          // Pen 3
        io_write(16'h7F00, 8'h4A);                          // Its colour
        io_write(16'h7F00, 8'h10);                          // Border pen
        io_write(16'h7F00, 8'h55);
        io_write(16'h7F00, 8'h8D);                          // Mode and ROM enables
        io_write(16'h7F00, 8'hC4);                          // RAM banking
        io_write(16'hBC00, 8'h0C);
        io_write(16'hBD00, 8'h30);
        io_write(16'hF700, 8'h82);
        io_write(16'hDF00, 8'h07);
        wb_before = wb_count;
        foreach (mf2_exp[k]) keys.push_back(k);
        foreach (keys[j]) begin
            cpu_access(1'b0, 16'h2000 | {3'b000, keys[j]}, 8'h00, rd, lat);
            check_equal("shadow byte", 32'(rd), 32'(mf2_exp[keys[j]]));
            check_equal("MF2 RAM read latency", 32'(lat), 32'd2);
        end
        cpu_access(1'b1, 16'h2400, 8'hA5, rd, lat);
        check_equal("MF2 RAM write latency", 32'(lat), 32'd2);
        cpu_access(1'b0, 16'h2400, 8'h00, rd, lat);
        check_equal("MF2 RAM read-back", 32'(rd), 32'hA5);
        check_equal("Wishbone cycles for MF2 RAM", 32'(wb_count - wb_before), 32'd0);

        // Hidden unit ignores FEE8, FEEA switches the overlay off
        m1_fetch(`MF2_HIDE_ADDR);
        io_write(`MF2_PORT_BASE, 8'h00);
        read_and_compare(16'h0123, {7'd0, 16'h0123}, "hidden read");
        pulse_nmi_key();
        m1_fetch(`MF2_NMI_ENTRY);
        read_and_compare(16'h0123, {`CPC_SLOT_MF2, 14'h0123}, "re-entry read");
        io_write(`MF2_PORT_BASE + 16'h0002, 8'h00);
        read_and_compare(16'h0123, {7'd0, 16'h0123}, "paged-out read");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* test/wb_sdram_model.sv */
`timescale 1ns/1ps

module wb_sdram_model (
    input  logic               clk_48,
    input  logic               RESET,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  cpc_pkg::mem_addr_t wb_adr,
    input  cpc_pkg::byte_t     wb_dat_w,
    output cpc_pkg::byte_t     wb_dat_r,
    output logic               wb_ack
);

    cpc_pkg::byte_t mem [cpc_pkg::mem_addr_t];   // Sparse, written bytes only
    logic [31:0]    lfsr_q;
    logic [1:0]     wait_q;                       // Cycles left before ack

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk_48) begin
        logic [31:0] s1;
        logic [31:0] s2;
        s1 = lfsr_next(lfsr_q);
        s2 = lfsr_next(s1);
        if (RESET) begin
            wb_ack <= 1'b0;
            wait_q <= 2'd0;
            lfsr_q <= 32'h2bc378ff;
        end else begin
            wb_ack <= 1'b0;                           // Single cycle ack
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    wb_ack <= 1'b1;
                    if (wb_we) mem[wb_adr] = wb_dat_w;
                    else if (mem.exists(wb_adr)) wb_dat_r <= mem[wb_adr];
                    else wb_dat_r <= wb_adr[7:0] ^ wb_adr[15:8] ^ {1'b0, wb_adr[22:16]};
                    wait_q <= {s1[0], s2[0]};         // Delay of the next transfer
                    lfsr_q <= s2;
                end
            end
        end
    end

endmodule

/* verilog/cpc_defs.svh */
`ifndef CPC_DEFS_SVH
`define CPC_DEFS_SVH

// ------------------------------------------------------------
// ROM slots in SDRAM, 16 KB each
`define CPC_SLOT_OS            9'h000
`define CPC_SLOT_BASIC         9'h100
`define CPC_SLOT_AMSDOS        9'h107
`define CPC_SLOT_MF2           9'h0FF
`define CPC_IMAGE_LIMIT        25'h0010000  // Bytes beyond this are dropped

// ------------------------------------------------------------
// Multiface Two addresses
`define MF2_PORT_BASE          16'hFEE8     // FEEA is base plus 2
`define MF2_NMI_ENTRY          16'h0066
`define MF2_HIDE_ADDR          16'h0065

// Shadow store locations in MF2 RAM
`define MF2_ST_PEN             13'h1FCF
`define MF2_ST_BORDER          13'h1FDF
`define MF2_ST_PALETTE_BASE    13'h1F90     // Low nibble is the pen
`define MF2_ST_MODE            13'h1FEF
`define MF2_ST_BANK            13'h1FFF
`define MF2_ST_CRTC_SEL        13'h1CFF
`define MF2_ST_CRTC_BASE       13'h1DB0     // Low nibble is the CRTC reg
`define MF2_ST_PPI             13'h17FF
`define MF2_ST_UROM            13'h1AAC

`endif

/* verilog/cpc_mem_top.sv */
`timescale 1ns/1ps

module cpc_mem_top (
    input  logic               clk_48,
    input  logic               RESET,
    input  cpc_pkg::ioctl_t    ioctl,
    output logic               ioctl_wait,
    output logic               rom_loaded,
    input  cpc_pkg::cpu_bus_t  cpu,
    input  logic               key_nmi,
    output cpc_pkg::byte_t     cpu_din,
    output logic               cpu_ack,
    output logic               nmi,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpc_pkg::mem_addr_t wb_adr,
    output cpc_pkg::byte_t     wb_dat_w,
    input  cpc_pkg::byte_t     wb_dat_r,
    input  logic               wb_ack
);

    cpc_pkg::mem_req_t boot_req;        // Loader to arbiter
    logic              boot_ack;
    logic              mf2_rom_sel, mf2_ram_sel;
    cpc_pkg::byte_t    mf2_rdata;
    logic              mf2_rdata_valid;

    rom_boot_loader rom_boot_loader_i (
        .clk_48(clk_48), .RESET(RESET), .ioctl(ioctl), .boot_ack(boot_ack),
        .boot_req(boot_req), .ioctl_wait(ioctl_wait), .rom_loaded(rom_loaded)
    );

    mf2_unit mf2_unit_i (
        .clk_48(clk_48), .RESET(RESET), .cpu(cpu), .key_nmi(key_nmi), .nmi(nmi),
        .mf2_rom_sel(mf2_rom_sel), .mf2_ram_sel(mf2_ram_sel),
        .mf2_rdata(mf2_rdata), .mf2_rdata_valid(mf2_rdata_valid)
    );

    // Single Wishbone master toward SDRAM
    mem_port_arbiter mem_port_arbiter_i (
        .clk_48(clk_48), .RESET(RESET), .boot_req(boot_req), .boot_ack(boot_ack),
        .cpu(cpu), .mf2_rom_sel(mf2_rom_sel), .mf2_ram_sel(mf2_ram_sel),
        .mf2_rdata(mf2_rdata), .mf2_rdata_valid(mf2_rdata_valid),
        .cpu_din(cpu_din), .cpu_ack(cpu_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

endmodule

/* verilog/cpc_pkg.sv */
package cpc_pkg;

    // ------------------------------------------------------------
    // Widths with a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [22:0] mem_addr_t;   // Slot in 22:14, offset in 13:0
    typedef logic [8:0]  rom_slot_t;
    typedef logic [12:0] mf2_addr_t;   // 8 KB MF2 RAM

    // Host download port
    typedef struct packed {
        logic        download;
        logic        wr;
        logic [24:0] addr;
        byte_t       dout;
        logic [7:0]  index;
    } ioctl_t;

    // CPU side of the bus
    typedef struct packed {
        cpu_addr_t addr;
        byte_t     dout;
        logic      mem_rd;  // Held until cpu_ack
        logic      mem_wr;
        logic      io_wr;
        logic      m1;
    } cpu_bus_t;

    // Single byte request toward memory
    typedef struct packed {
        logic      valid;
        logic      we;
        mem_addr_t addr;
        byte_t     data;
    } mem_req_t;

    typedef enum logic [1:0] {
        MF2_OFF,
        MF2_NMI_PENDING,
        MF2_ACTIVE,
        MF2_HIDDEN
    } mf2_state_t;

endpackage

/* verilog/mem_port_arbiter.sv */
`timescale 1ns/1ps

`include "cpc_defs.svh"

module mem_port_arbiter (
    input  logic               clk_48,
    input  logic               RESET,
    input  cpc_pkg::mem_req_t  boot_req,
    output logic               boot_ack,
    input  cpc_pkg::cpu_bus_t  cpu,
    input  logic               mf2_rom_sel,
    input  logic               mf2_ram_sel,
    input  cpc_pkg::byte_t     mf2_rdata,
    input  logic               mf2_rdata_valid,
    output cpc_pkg::byte_t     cpu_din,
    output logic               cpu_ack,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output cpc_pkg::mem_addr_t wb_adr,
    output cpc_pkg::byte_t     wb_dat_w,
    input  cpc_pkg::byte_t     wb_dat_r,
    input  logic               wb_ack
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_WB, ARB_MF2} arb_state_t;

    arb_state_t state_q;
    logic       from_boot_q;   // Owner of the open Wishbone cycle
    logic       cpu_req;

    // Request still visible in its ack cycle, so skip it there
    assign cpu_req = (cpu.mem_rd || cpu.mem_wr) && !cpu_ack;

    // ------------------------------------------------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            state_q  <= ARB_IDLE;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            cpu_ack  <= 1'b0;
            boot_ack <= 1'b0;
        end else begin
            cpu_ack  <= 1'b0;       // Both acks are single pulses
            boot_ack <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (boot_req.valid && !boot_ack) begin       // Loader first
                        state_q     <= ARB_WB;
                        wb_cyc      <= 1'b1;
                        wb_stb      <= 1'b1;
                        wb_we       <= boot_req.we;
                        wb_adr      <= boot_req.addr;
                        wb_dat_w    <= boot_req.data;
                        from_boot_q <= 1'b1;
                    end else if (cpu_req && mf2_ram_sel) begin
                        state_q <= ARB_MF2;                       // Served inside MF2
                    end else if (cpu_req && mf2_rom_sel && cpu.mem_wr) begin
                        cpu_ack <= 1'b1;                          // ROM overlay, drop it
                    end else if (cpu_req) begin
                        state_q     <= ARB_WB;
                        wb_cyc      <= 1'b1;
                        wb_stb      <= 1'b1;
                        wb_we       <= cpu.mem_wr;
                        wb_adr      <= mf2_rom_sel ? {`CPC_SLOT_MF2, cpu.addr[13:0]} :
                                                     {7'd0, cpu.addr};
                        wb_dat_w    <= cpu.dout;
                        from_boot_q <= 1'b0;
                    end
                end
                ARB_WB: begin
                    if (wb_ack) begin
                        state_q <= ARB_IDLE;
                        wb_cyc  <= 1'b0;
                        wb_stb  <= 1'b0;
                        if (from_boot_q) boot_ack <= 1'b1;
                        else             cpu_ack  <= 1'b1;
                        cpu_din <= wb_dat_r;                      // Ignored on writes
                    end
                end
                default: begin                                    // MF2 RAM
                    if (mf2_rdata_valid) begin
                        state_q <= ARB_IDLE;
                        cpu_ack <= 1'b1;
                        cpu_din <= mf2_rdata;
                    end
                end
            endcase
        end
    end

    // Open strobe stays inside its cycle with a steady request until ack
    a_wb_hold: assert property (@(posedge clk_48) disable iff (RESET)
        wb_stb && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we));

endmodule

/* verilog/mf2_unit.sv */
`timescale 1ns/1ps

`include "cpc_defs.svh"

module mf2_unit (
    input  logic              clk_48,
    input  logic              RESET,
    input  cpc_pkg::cpu_bus_t cpu,
    input  logic              key_nmi,
    output logic              nmi,
    output logic              mf2_rom_sel,
    output logic              mf2_ram_sel,
    output cpc_pkg::byte_t    mf2_rdata,
    output logic              mf2_rdata_valid
);

    cpc_pkg::mf2_state_t state_q;
    cpc_pkg::byte_t      ram [0:2**$bits(cpc_pkg::mf2_addr_t)-1];
    cpc_pkg::mf2_addr_t  store_addr;
    cpc_pkg::mf2_addr_t  ram_wa;
    logic                ram_we;
    logic [4:0]          pen_q;        // Last pen selected on 7F
    logic [3:0]          crtc_q;       // Last CRTC register on BC
    logic                old_key_nmi, old_m1, old_io_wr;
    logic                nmi_rise, m1_rise, io_wr_rise, port_hit;

    assign nmi_rise   = key_nmi && !old_key_nmi;
    assign m1_rise    = cpu.m1 && !old_m1;
    assign io_wr_rise = cpu.io_wr && !old_io_wr;
    assign port_hit   = (cpu.addr & ~16'h0002) == `MF2_PORT_BASE;  // FEE8 or FEEA

    // Overlay decode, ROM in 0000-1FFF and RAM in 2000-3FFF
    assign mf2_rom_sel = (state_q == cpc_pkg::MF2_ACTIVE) && (cpu.addr[15:13] == 3'b000);
    assign mf2_ram_sel = (state_q == cpc_pkg::MF2_ACTIVE) && (cpu.addr[15:13] == 3'b001);

    // ------------------------------------------------------------
    // Shadow address of an I/O register write
    always_comb begin
        case (cpu.addr[15:8])
            8'h7F: begin                                // Gate array
                case (cpu.dout[7:6])
                    2'b00:   store_addr = `MF2_ST_PEN;
                    2'b01:   store_addr = pen_q[4] ? `MF2_ST_BORDER :
                                          (`MF2_ST_PALETTE_BASE | {9'd0, pen_q[3:0]});
                    2'b10:   store_addr = `MF2_ST_MODE;
                    default: store_addr = `MF2_ST_BANK;
                endcase
            end
            8'hBC:   store_addr = `MF2_ST_CRTC_SEL;
            8'hBD:   store_addr = `MF2_ST_CRTC_BASE | {9'd0, crtc_q};
            8'hF7:   store_addr = `MF2_ST_PPI;         // 8255 control
            8'hDF:   store_addr = `MF2_ST_UROM;        // Upper ROM select
            default: store_addr = '0;                  // Not shadowed
        endcase
    end

    // Write port, shadow stores win over CPU writes
    always_comb begin
        ram_we = 1'b0;
        ram_wa = cpu.addr[12:0];
        if (io_wr_rise && (store_addr != '0)) begin
            ram_we = 1'b1;
            ram_wa = store_addr;
        end else if (cpu.mem_wr && mf2_ram_sel) begin
            ram_we = 1'b1;
        end
    end

    always_ff @(posedge clk_48) begin
        if (ram_we) ram[ram_wa] <= cpu.dout;
        mf2_rdata <= ram[cpu.addr[12:0]];
    end

    // ------------------------------------------------------------
    // Edge detect, state machine, tracked indices
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            state_q         <= cpc_pkg::MF2_OFF;
            nmi             <= 1'b0;
            pen_q           <= '0;
            crtc_q          <= '0;
            old_key_nmi     <= 1'b0;
            old_m1          <= 1'b0;
            old_io_wr       <= 1'b0;
            mf2_rdata_valid <= 1'b0;
        end else begin
            old_key_nmi     <= key_nmi;
            old_m1          <= cpu.m1;
            old_io_wr       <= cpu.io_wr;
            mf2_rdata_valid <= (cpu.mem_rd || cpu.mem_wr) && mf2_ram_sel;
            case (state_q)
                cpc_pkg::MF2_OFF, cpc_pkg::MF2_HIDDEN: begin
                    if (nmi_rise) begin
                        state_q <= cpc_pkg::MF2_NMI_PENDING;
                        nmi     <= 1'b1;
                    end else if (io_wr_rise && port_hit && !cpu.addr[1] &&
                                 state_q == cpc_pkg::MF2_OFF) begin
                        state_q <= cpc_pkg::MF2_ACTIVE;   // FEE8, unless hidden
                    end
                end
                cpc_pkg::MF2_NMI_PENDING: begin
                    if (m1_rise && cpu.addr == `MF2_NMI_ENTRY) begin
                        state_q <= cpc_pkg::MF2_ACTIVE;
                        nmi     <= 1'b0;
                    end
                end
                default: begin                            // Active
                    if (m1_rise && cpu.addr == `MF2_HIDE_ADDR) state_q <= cpc_pkg::MF2_HIDDEN;
                    else if (io_wr_rise && port_hit && cpu.addr[1]) state_q <= cpc_pkg::MF2_OFF;
                end
            endcase
            if (io_wr_rise && cpu.addr[15:8] == 8'h7F && cpu.dout[7:6] == 2'b00)
                pen_q <= cpu.dout[4:0];
            if (io_wr_rise && cpu.addr[15:8] == 8'hBC)
                crtc_q <= cpu.dout[3:0];
        end
    end

    a_nmi_not_active: assert property (@(posedge clk_48) disable iff (RESET)
        !(nmi && state_q == cpc_pkg::MF2_ACTIVE));

endmodule

/* verilog/rom_boot_loader.sv */
`timescale 1ns/1ps

`include "cpc_defs.svh"

module rom_boot_loader (
    input  logic              clk_48,
    input  logic              RESET,
    input  cpc_pkg::ioctl_t   ioctl,
    input  logic              boot_ack,
    output cpc_pkg::mem_req_t boot_req,
    output logic              ioctl_wait,
    output logic              rom_loaded
);

    cpc_pkg::rom_slot_t slot;
    logic               take;
    logic               old_download;

    // ------------------------------------------------------------
    // Slot decode, bits 15:14 pick the ROM
    always_comb begin
        case (ioctl.addr[15:14])
            2'd0:    slot = `CPC_SLOT_OS;
            2'd1:    slot = `CPC_SLOT_BASIC;
            2'd2:    slot = `CPC_SLOT_AMSDOS;
            default: slot = `CPC_SLOT_MF2;
        endcase
    end

    // System ROM image only, second half of 128 KB is skipped
    assign take = ioctl.download && ioctl.wr && (ioctl.index == 8'd0) &&
                  (ioctl.addr < `CPC_IMAGE_LIMIT) && !boot_req.valid;

    always_ff @(posedge clk_48) begin
        if (take) begin
            boot_req.we   <= 1'b1;                      // Loader only writes
            boot_req.addr <= {slot, ioctl.addr[13:0]};
            boot_req.data <= ioctl.dout;
        end
        if (RESET) begin
            boot_req.valid <= 1'b0;
        end else if (boot_req.valid) begin
            if (boot_ack) boot_req.valid <= 1'b0;       // Drops the cycle after ack
        end else if (take) begin
            boot_req.valid <= 1'b1;
        end
    end

    // Host stalls while a byte is outstanding
    assign ioctl_wait = boot_req.valid;

    // Falling edge of download marks the ROMs as present
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            old_download <= 1'b0;
            rom_loaded   <= 1'b0;
        end else begin
            old_download <= ioctl.download;
            if (old_download && !ioctl.download) rom_loaded <= 1'b1;
        end
    end

    // Request fields frozen until the arbiter takes them
    a_req_hold: assert property (@(posedge clk_48) disable iff (RESET)
        boot_req.valid && !boot_ack |=> boot_req.valid && $stable(boot_req));

endmodule
